// File: source/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define ID_XLEN     32
`define ID_REG_W    5
`define ID_ALUOP_W  12 // add sub slt sltu and nor or xor sll srl sra lui
`define ID_MEMOP_W  8  // lb lbu lh lhu lw sb sh sw
`define ID_MDUOP_W  8  // mult multu div divu mfhi mthi mflo mtlo
`define ID_EXC_W    3

// exception vector bits
`define EXC_SYSCALL 0
`define EXC_BREAK   1
`define EXC_RI      2

`define OP_SPECIAL  6'h00
`define OP_REGIMM   6'h01
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_BLEZ     6'h06
`define OP_BGTZ     6'h07
`define OP_ADDI     6'h08
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f
`define OP_LB       6'h20
`define OP_LH       6'h21
`define OP_LW       6'h23
`define OP_LBU      6'h24
`define OP_LHU      6'h25
`define OP_SB       6'h28
`define OP_SH       6'h29
`define OP_SW       6'h2b

`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_SLLV     6'h04
`define FN_SRLV     6'h06
`define FN_SRAV     6'h07
`define FN_JR       6'h08
`define FN_JALR     6'h09
`define FN_SYSCALL  6'h0c
`define FN_BREAK    6'h0d
`define FN_MFHI     6'h10
`define FN_MTHI     6'h11
`define FN_MFLO     6'h12
`define FN_MTLO     6'h13
`define FN_MULT     6'h18
`define FN_MULTU    6'h19
`define FN_DIV      6'h1a
`define FN_DIVU     6'h1b
`define FN_ADD      6'h20
`define FN_ADDU     6'h21
`define FN_SUB      6'h22
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// regimm branches, selected by rt
`define RT_BLTZ     5'h00
`define RT_BGEZ     5'h01
`define RT_BLTZAL   5'h10
`define RT_BGEZAL   5'h11

`endif

// File: source/id_pkg.sv
`include "id_macros.svh"

package id_pkg;

	typedef struct packed {
		logic [5:0]           opcode;
		logic [`ID_REG_W-1:0] rs;
		logic [`ID_REG_W-1:0] rt;
		logic [`ID_REG_W-1:0] rd;
		logic [`ID_REG_W-1:0] sa;
		logic [5:0]           funct;
	} id_r_fields_t;

	typedef struct packed {
		logic [5:0]           opcode;
		logic [`ID_REG_W-1:0] rs;
		logic [`ID_REG_W-1:0] rt;
		logic [15:0]          imm;
	} id_i_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target; // word index inside the 256MB region
	} id_j_fields_t;

	// one instruction word, three views
	typedef union packed {
		id_r_fields_t r;
		id_i_fields_t i;
		id_j_fields_t j;
	} id_inst_u;

endpackage

// File: source/id_inst_decoder.sv
`include "id_macros.svh"

module id_inst_decoder import id_pkg::*; (
	input  id_inst_u               inst_i,
	output logic [`ID_ALUOP_W-1:0] alu_op_o,
	output logic [`ID_MEMOP_W-1:0] mem_op_o,
	output logic [`ID_MDUOP_W-1:0] mdu_op_o,
	output logic                   src1_is_sa_o,
	output logic                   src2_imm_s_o,
	output logic                   src2_imm_u_o,
	output logic                   waddr_is_rt_o,
	output logic                   writes_gpr_o,
	output logic                   reads_rs_o,
	output logic                   reads_rt_o,
	output logic                   syscall_o,
	output logic                   break_o,
	output logic                   known_o
);

	wire [5:0] op = inst_i.i.opcode;
	wire [5:0] fn = inst_i.r.funct;
	wire special = (op == `OP_SPECIAL);
	wire sa_zero = (inst_i.r.sa == '0);
	wire rd_zero = (inst_i.r.rd == '0);
	wire rs_zero = (inst_i.r.rs == '0); // immediate shifts
	wire md_ok = special & sa_zero & rd_zero;
	logic no_write;

	assign mem_op_o = {
		op == `OP_SW,
		op == `OP_SH,
		op == `OP_SB,
		op == `OP_LW,
		op == `OP_LHU,
		op == `OP_LH,
		op == `OP_LBU,
		op == `OP_LB
	};

	assign mdu_op_o = {
		special & (fn == `FN_MTLO),
		special & sa_zero & (fn == `FN_MFLO),
		special & (fn == `FN_MTHI),
		special & sa_zero & (fn == `FN_MFHI),
		md_ok & (fn == `FN_DIVU),
		md_ok & (fn == `FN_DIV),
		md_ok & (fn == `FN_MULTU),
		md_ok & (fn == `FN_MULT)
	};

	always_comb begin
		alu_op_o = '0;
		src1_is_sa_o = 1'b0;
		src2_imm_s_o = 1'b0;
		src2_imm_u_o = 1'b0;
		waddr_is_rt_o = 1'b1; // I-type default
		reads_rs_o = 1'b1;
		reads_rt_o = 1'b0;
		syscall_o = 1'b0;
		break_o = 1'b0;
		no_write = 1'b0;
		case (op)
			`OP_SPECIAL: begin
				waddr_is_rt_o = 1'b0;
				reads_rt_o = 1'b1;
				case (fn)
					`FN_ADD, `FN_ADDU: alu_op_o[0] = sa_zero;
					`FN_SUB, `FN_SUBU: alu_op_o[1] = sa_zero;
					`FN_SLT: alu_op_o[2] = sa_zero;
					`FN_SLTU: alu_op_o[3] = sa_zero;
					`FN_AND: alu_op_o[4] = sa_zero;
					`FN_NOR: alu_op_o[5] = sa_zero;
					`FN_OR: alu_op_o[6] = sa_zero;
					`FN_XOR: alu_op_o[7] = sa_zero;
					`FN_SLLV: alu_op_o[8] = sa_zero;
					`FN_SRLV: alu_op_o[9] = sa_zero;
					`FN_SRAV: alu_op_o[10] = sa_zero;
					`FN_SLL, `FN_SRL, `FN_SRA: begin
						alu_op_o[8] = rs_zero & (fn == `FN_SLL);
						alu_op_o[9] = rs_zero & (fn == `FN_SRL);
						alu_op_o[10] = rs_zero & (fn == `FN_SRA);
						src1_is_sa_o = 1'b1;
						reads_rs_o = 1'b0;
					end
					`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU: no_write = 1'b1; // result to hi/lo
					`FN_MTHI, `FN_MTLO: begin
						reads_rt_o = 1'b0;
						no_write = 1'b1;
					end
					`FN_MFHI, `FN_MFLO: begin
						reads_rs_o = 1'b0;
						reads_rt_o = 1'b0;
					end
					`FN_SYSCALL: begin
						syscall_o = 1'b1;
						no_write = 1'b1;
					end
					`FN_BREAK: begin
						break_o = 1'b1;
						no_write = 1'b1;
					end
					default: begin // jr, jalr or unused
						reads_rs_o = 1'b0;
						reads_rt_o = 1'b0;
					end
				endcase
			end
			`OP_ADDI, `OP_ADDIU: begin
				alu_op_o[0] = 1'b1;
				src2_imm_s_o = 1'b1;
			end
			`OP_SLTI: begin
				alu_op_o[2] = 1'b1;
				src2_imm_s_o = 1'b1;
			end
			`OP_SLTIU: begin
				alu_op_o[3] = 1'b1;
				src2_imm_s_o = 1'b1;
			end
			`OP_ANDI: begin
				alu_op_o[4] = 1'b1;
				src2_imm_u_o = 1'b1;
			end
			`OP_ORI: begin
				alu_op_o[6] = 1'b1;
				src2_imm_u_o = 1'b1;
			end
			`OP_XORI: begin
				alu_op_o[7] = 1'b1;
				src2_imm_u_o = 1'b1;
			end
			`OP_LUI: begin
				alu_op_o[11] = (inst_i.i.rs == '0);
				src2_imm_u_o = 1'b1;
				reads_rs_o = 1'b0;
			end
			`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW: begin
				alu_op_o[0] = 1'b1; // address add
				src2_imm_s_o = 1'b1;
			end
			`OP_SB, `OP_SH, `OP_SW: begin
				alu_op_o[0] = 1'b1;
				src2_imm_s_o = 1'b1;
				reads_rt_o = 1'b1;
				no_write = 1'b1;
			end
			default: reads_rs_o = 1'b0; // branches, jumps, unused
		endcase
	end

	assign known_o = (|alu_op_o) | (|mem_op_o) | (|mdu_op_o) | syscall_o | break_o;
	assign writes_gpr_o = known_o & ~no_write;

	always_comb begin
		assert ($onehot0(alu_op_o) && $onehot0(mem_op_o))
			else $error("id_inst_decoder: more than one op bit set");
	end

endmodule

// File: source/id_branch_unit.sv
`include "id_macros.svh"

module id_branch_unit import id_pkg::*; (
	input  id_inst_u             inst_i,
	input  logic [`ID_XLEN-1:0]  pc_i,
	input  logic [`ID_XLEN-1:0]  rs_data_i,
	input  logic [`ID_XLEN-1:0]  rt_data_i,
	output logic                 branch_en_o,
	output logic [`ID_XLEN-1:0]  branch_pc_o,
	output logic                 is_branch_o,
	output logic                 link_o,
	output logic                 reads_rs_o,
	output logic                 reads_rt_o
);

	wire [5:0] op = inst_i.i.opcode;
	wire special = (op == `OP_SPECIAL);
	wire regimm = (op == `OP_REGIMM);
	wire rt_zero = (inst_i.i.rt == '0);

	wire inst_beq = (op == `OP_BEQ);
	wire inst_bne = (op == `OP_BNE);
	wire inst_blez = (op == `OP_BLEZ) & rt_zero;
	wire inst_bgtz = (op == `OP_BGTZ) & rt_zero;
	wire inst_bltz = regimm & (inst_i.i.rt == `RT_BLTZ);
	wire inst_bgez = regimm & (inst_i.i.rt == `RT_BGEZ);
	wire inst_bltzal = regimm & (inst_i.i.rt == `RT_BLTZAL);
	wire inst_bgezal = regimm & (inst_i.i.rt == `RT_BGEZAL);
	wire inst_j = (op == `OP_J);
	wire inst_jal = (op == `OP_JAL);
	wire inst_jr = special & (inst_i.r.funct == `FN_JR) & rt_zero
		& (inst_i.r.rd == '0) & (inst_i.r.sa == '0);
	wire inst_jalr = special & (inst_i.r.funct == `FN_JALR) & rt_zero & (inst_i.r.sa == '0);

	wire b_type = inst_beq | inst_bne | inst_blez | inst_bgtz
		| inst_bltz | inst_bgez | inst_bltzal | inst_bgezal;
	wire j_type = inst_j | inst_jal;
	wire r_type = inst_jr | inst_jalr;

	// rs compares straight off the register file
	wire lz = rs_data_i[`ID_XLEN-1];
	wire lez = lz | (rs_data_i == '0);
	wire eq = (rs_data_i == rt_data_i);

	wire [`ID_XLEN-1:0] pcp4 = pc_i + `ID_XLEN'd4;
	wire [15:0] imm = inst_i.i.imm;
	wire [`ID_XLEN-1:0] b_target = pcp4 + {{(`ID_XLEN-18){imm[15]}}, imm, 2'b00};
	wire [`ID_XLEN-1:0] j_target = {pcp4[`ID_XLEN-1 -: 4], inst_i.j.target, 2'b00};

	assign branch_en_o = (inst_beq & eq) | (inst_bne & ~eq)
		| ((inst_bgez | inst_bgezal) & ~lz) | ((inst_bltz | inst_bltzal) & lz)
		| (inst_blez & lez) | (inst_bgtz & ~lez)
		| j_type | r_type;

	assign branch_pc_o = b_type ? b_target : j_type ? j_target : rs_data_i;

	assign is_branch_o = b_type | j_type | r_type; // next word is the delay slot
	assign link_o = inst_jal | inst_jalr | inst_bgezal | inst_bltzal;
	assign reads_rs_o = b_type | r_type;
	assign reads_rt_o = inst_beq | inst_bne;

	always_comb begin
		assert (!branch_en_o || is_branch_o)
			else $error("id_branch_unit: taken without a branch");
	end

endmodule

// File: source/id_ex_latch.sv
`include "id_macros.svh"

module id_ex_latch import id_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   stall_i,
	input  logic                   flush_i,
	input  id_inst_u               inst_i,
	input  logic [`ID_XLEN-1:0]    pc_i,
	input  logic                   inslot_i,
	input  logic [`ID_XLEN-1:0]    reg1data_i,
	input  logic [`ID_XLEN-1:0]    reg2data_i,
	input  logic [`ID_ALUOP_W-1:0] alu_op_i,
	input  logic [`ID_MEMOP_W-1:0] mem_op_i,
	input  logic [`ID_MDUOP_W-1:0] mdu_op_i,
	input  logic                   src1_is_sa_i,
	input  logic                   src2_imm_s_i,
	input  logic                   src2_imm_u_i,
	input  logic                   waddr_is_rt_i,
	input  logic                   writes_gpr_i,
	input  logic                   reads_rs_i,
	input  logic                   reads_rt_i,
	input  logic                   syscall_i,
	input  logic                   break_i,
	input  logic                   known_i,
	input  logic                   br_known_i,
	input  logic                   link_i,
	input  logic                   br_reads_rs_i,
	input  logic                   br_reads_rt_i,
	output logic                   ren1_o,
	output logic                   ren2_o,
	output logic [`ID_XLEN-1:0]    pc_o,
	output logic                   inslot_o,
	output logic [`ID_XLEN-1:0]    opr1_o,
	output logic [`ID_XLEN-1:0]    opr2_o,
	output logic [`ID_XLEN-1:0]    offset_o,
	output logic [`ID_XLEN-1:0]    rtvalue_o,
	output logic                   wren_o,
	output logic [`ID_REG_W-1:0]   waddr_o,
	output logic [`ID_ALUOP_W-1:0] aluop_o,
	output logic [`ID_MEMOP_W-1:0] memop_o,
	output logic [`ID_MDUOP_W-1:0] mduop_o,
	output logic                   nofwd_o,
	output logic [`ID_EXC_W-1:0]   excs_o,
	output logic                   has_exc_o
);

	wire [15:0] imm = inst_i.i.imm;
	wire [`ID_XLEN-1:0] sign_ext = {{(`ID_XLEN-16){imm[15]}}, imm};
	wire [`ID_XLEN-1:0] zero_ext = {{(`ID_XLEN-16){1'b0}}, imm};
	wire [`ID_XLEN-1:0] sa_ext = {{(`ID_XLEN-`ID_REG_W){1'b0}}, inst_i.r.sa};

	// link writes pc+8 as pc + 8 through the alu add
	wire [`ID_XLEN-1:0] opr1_d = src1_is_sa_i ? sa_ext : link_i ? pc_i : reg1data_i;
	wire [`ID_XLEN-1:0] opr2_d = src2_imm_s_i ? sign_ext
		: src2_imm_u_i ? zero_ext
		: link_i ? `ID_XLEN'd8
		: reg2data_i;
	wire [`ID_REG_W-1:0] waddr_d = link_i ? {`ID_REG_W{1'b1}}
		: waddr_is_rt_i ? inst_i.i.rt
		: inst_i.r.rd;
	wire [`ID_ALUOP_W-1:0] aluop_d = alu_op_i | {{(`ID_ALUOP_W-1){1'b0}}, link_i};
	wire nofwd_d = (|mem_op_i[4:0]) | mdu_op_i[4] | mdu_op_i[6]; // loads, mfhi, mflo
	logic [`ID_EXC_W-1:0] excs_d;

	assign excs_d[`EXC_SYSCALL] = syscall_i;
	assign excs_d[`EXC_BREAK] = break_i;
	assign excs_d[`EXC_RI] = ~(known_i | br_known_i);

	assign ren1_o = reads_rs_i | br_reads_rs_i;
	assign ren2_o = reads_rt_i | br_reads_rt_i;

	always_ff @(posedge clk) begin
		if (rst_i || (flush_i && !stall_i)) begin // bubble
			{pc_o, inslot_o, opr1_o, opr2_o, offset_o, rtvalue_o, wren_o, waddr_o,
				aluop_o, memop_o, mduop_o, nofwd_o, excs_o, has_exc_o} <= '0;
		end else if (!stall_i) begin
			pc_o <= pc_i;
			inslot_o <= inslot_i;
			opr1_o <= opr1_d;
			opr2_o <= opr2_d;
			offset_o <= sign_ext;
			rtvalue_o <= reg2data_i; // store data
			wren_o <= writes_gpr_i | link_i;
			waddr_o <= waddr_d;
			aluop_o <= aluop_d;
			memop_o <= mem_op_i;
			mduop_o <= mdu_op_i;
			nofwd_o <= nofwd_d;
			excs_o <= excs_d;
			has_exc_o <= |excs_d;
		end
	end

	assert property (@(posedge clk) disable iff (rst_i) (flush_i && !stall_i) |=> !wren_o)
		else $error("id_ex_latch: write enable survived a flush");

endmodule

// File: source/id_stage.sv
`include "id_macros.svh"

module id_stage import id_pkg::*; (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic                   stall_i,
	input  logic                   flush_i,
	input  logic [`ID_XLEN-1:0]    pc_i,
	input  id_inst_u               inst_i,
	input  logic                   inslot_i,
	input  logic [`ID_XLEN-1:0]    reg1data_i,
	input  logic [`ID_XLEN-1:0]    reg2data_i,
	output logic [`ID_REG_W-1:0]   reg1addr_o,
	output logic [`ID_REG_W-1:0]   reg2addr_o,
	output logic                   ren1_o,
	output logic                   ren2_o,
	output logic                   branch_en_o,
	output logic [`ID_XLEN-1:0]    branch_pc_o,
	output logic                   next_inslot_o,
	output logic [`ID_XLEN-1:0]    pc_o,
	output logic                   inslot_o,
	output logic [`ID_XLEN-1:0]    opr1_o,
	output logic [`ID_XLEN-1:0]    opr2_o,
	output logic [`ID_XLEN-1:0]    offset_o,
	output logic [`ID_XLEN-1:0]    rtvalue_o,
	output logic                   wren_o,
	output logic [`ID_REG_W-1:0]   waddr_o,
	output logic [`ID_ALUOP_W-1:0] aluop_o,
	output logic [`ID_MEMOP_W-1:0] memop_o,
	output logic [`ID_MDUOP_W-1:0] mduop_o,
	output logic                   nofwd_o,
	output logic [`ID_EXC_W-1:0]   excs_o,
	output logic                   has_exc_o
);

	logic [`ID_ALUOP_W-1:0] alu_op;
	logic [`ID_MEMOP_W-1:0] mem_op;
	logic [`ID_MDUOP_W-1:0] mdu_op;
	logic src1_is_sa;
	logic src2_imm_s;
	logic src2_imm_u;
	logic waddr_is_rt;
	logic writes_gpr;
	logic dec_reads_rs;
	logic dec_reads_rt;
	logic syscall;
	logic brk;
	logic known;
	logic br_link;
	logic br_reads_rs;
	logic br_reads_rt;

	// register file is read in the same cycle
	assign reg1addr_o = inst_i.r.rs;
	assign reg2addr_o = inst_i.r.rt;

	id_inst_decoder u_decoder (
		.inst_i        (inst_i),
		.alu_op_o      (alu_op),
		.mem_op_o      (mem_op),
		.mdu_op_o      (mdu_op),
		.src1_is_sa_o  (src1_is_sa),
		.src2_imm_s_o  (src2_imm_s),
		.src2_imm_u_o  (src2_imm_u),
		.waddr_is_rt_o (waddr_is_rt),
		.writes_gpr_o  (writes_gpr),
		.reads_rs_o    (dec_reads_rs),
		.reads_rt_o    (dec_reads_rt),
		.syscall_o     (syscall),
		.break_o       (brk),
		.known_o       (known)
	);

	id_branch_unit u_branch (
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.rs_data_i   (reg1data_i),
		.rt_data_i   (reg2data_i),
		.branch_en_o (branch_en_o),
		.branch_pc_o (branch_pc_o),
		.is_branch_o (next_inslot_o),
		.link_o      (br_link),
		.reads_rs_o  (br_reads_rs),
		.reads_rt_o  (br_reads_rt)
	);

	id_ex_latch u_latch (
		.clk           (clk),
		.rst_i         (rst_i),
		.stall_i       (stall_i),
		.flush_i       (flush_i),
		.inst_i        (inst_i),
		.pc_i          (pc_i),
		.inslot_i      (inslot_i),
		.reg1data_i    (reg1data_i),
		.reg2data_i    (reg2data_i),
		.alu_op_i      (alu_op),
		.mem_op_i      (mem_op),
		.mdu_op_i      (mdu_op),
		.src1_is_sa_i  (src1_is_sa),
		.src2_imm_s_i  (src2_imm_s),
		.src2_imm_u_i  (src2_imm_u),
		.waddr_is_rt_i (waddr_is_rt),
		.writes_gpr_i  (writes_gpr),
		.reads_rs_i    (dec_reads_rs),
		.reads_rt_i    (dec_reads_rt),
		.syscall_i     (syscall),
		.break_i       (brk),
		.known_i       (known),
		.br_known_i    (next_inslot_o),
		.link_i        (br_link),
		.br_reads_rs_i (br_reads_rs),
		.br_reads_rt_i (br_reads_rt),
		.ren1_o        (ren1_o),
		.ren2_o        (ren2_o),
		.pc_o          (pc_o),
		.inslot_o      (inslot_o),
		.opr1_o        (opr1_o),
		.opr2_o        (opr2_o),
		.offset_o      (offset_o),
		.rtvalue_o     (rtvalue_o),
		.wren_o        (wren_o),
		.waddr_o       (waddr_o),
		.aluop_o       (aluop_o),
		.memop_o       (memop_o),
		.mduop_o       (mduop_o),
		.nofwd_o       (nofwd_o),
		.excs_o        (excs_o),
		.has_exc_o     (has_exc_o)
	);

endmodule

// File: sim/id_stage_tb.sv
`include "id_macros.svh"

module id_stage_tb import id_pkg::*; ();

	localparam int MAX_CYCLES = 400; // the tests need about 70 cycles

	logic clk;
	logic rst;
	logic stall;
	logic flush;
	logic [`ID_XLEN-1:0] pc;
	id_inst_u inst;
	logic inslot;
	logic [`ID_XLEN-1:0] reg1data;
	logic [`ID_XLEN-1:0] reg2data;
	logic [`ID_REG_W-1:0] reg1addr;
	logic [`ID_REG_W-1:0] reg2addr;
	logic ren1;
	logic ren2;
	logic branch_en;
	logic [`ID_XLEN-1:0] branch_pc;
	logic next_inslot;
	logic [`ID_XLEN-1:0] ex_pc;
	logic ex_inslot;
	logic [`ID_XLEN-1:0] opr1;
	logic [`ID_XLEN-1:0] opr2;
	logic [`ID_XLEN-1:0] offset;
	logic [`ID_XLEN-1:0] rtvalue;
	logic wren;
	logic [`ID_REG_W-1:0] waddr;
	logic [`ID_ALUOP_W-1:0] aluop;
	logic [`ID_MEMOP_W-1:0] memop;
	logic [`ID_MDUOP_W-1:0] mduop;
	logic nofwd;
	logic [`ID_EXC_W-1:0] excs;
	logic has_exc;

	integer seed = 32'h0dd0_3e6c;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	int cycles = 0;

	id_stage uut (
		.clk           (clk),
		.rst_i         (rst),
		.stall_i       (stall),
		.flush_i       (flush),
		.pc_i          (pc),
		.inst_i        (inst),
		.inslot_i      (inslot),
		.reg1data_i    (reg1data),
		.reg2data_i    (reg2data),
		.reg1addr_o    (reg1addr),
		.reg2addr_o    (reg2addr),
		.ren1_o        (ren1),
		.ren2_o        (ren2),
		.branch_en_o   (branch_en),
		.branch_pc_o   (branch_pc),
		.next_inslot_o (next_inslot),
		.pc_o          (ex_pc),
		.inslot_o      (ex_inslot),
		.opr1_o        (opr1),
		.opr2_o        (opr2),
		.offset_o      (offset),
		.rtvalue_o     (rtvalue),
		.wren_o        (wren),
		.waddr_o       (waddr),
		.aluop_o       (aluop),
		.memop_o       (memop),
		.mduop_o       (mduop),
		.nofwd_o       (nofwd),
		.excs_o        (excs),
		.has_exc_o     (has_exc)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	task automatic check_word(input string what, input logic [`ID_XLEN-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input string what, input logic [`ID_REG_W-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_aluop(input string what, input logic [`ID_ALUOP_W-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_memop(input string what, input logic [`ID_MEMOP_W-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_mduop(input string what, input logic [`ID_MDUOP_W-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_exc(input string what, input logic [`ID_EXC_W-1:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	function automatic id_inst_u rtype(input logic [`ID_REG_W-1:0] rs, rt, rd, sa,
		input logic [5:0] fn);
		id_inst_u w;
		w.r = {`OP_SPECIAL, rs, rt, rd, sa, fn};
		return w;
	endfunction

	function automatic id_inst_u itype(input logic [5:0] op,
		input logic [`ID_REG_W-1:0] rs, rt, input logic [15:0] imm);
		id_inst_u w;
		w.i = {op, rs, rt, imm};
		return w;
	endfunction

	function automatic id_inst_u jtype(input logic [5:0] op, input logic [25:0] index);
		id_inst_u w;
		w.j = {op, index};
		return w;
	endfunction

	// drive on the rising edge, look at the falling one
	task automatic apply(input id_inst_u w, input logic [`ID_XLEN-1:0] addr, d1, d2);
		@(posedge clk);
		inst <= w;
		pc <= addr;
		reg1data <= d1;
		reg2data <= d2;
		@(negedge clk);
	endtask

	task automatic next_cycle;
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("%-14s passed", name);
		end else begin
			failed_tests++;
			$display("%-14s %0d mismatches", name, errors - errs_before);
		end
	endtask

	task automatic expect_bubble;
		check_bit("wren_o", wren, 1'b0);
		check_aluop("aluop_o", aluop, '0);
		check_memop("memop_o", memop, '0);
		check_mduop("mduop_o", mduop, '0);
		check_exc("excs_o", excs, '0);
		check_bit("has_exc_o", has_exc, 1'b0);
		check_bit("nofwd_o", nofwd, 1'b0);
		check_word("opr1_o", opr1, '0);
		check_word("opr2_o", opr2, '0);
		check_word("pc_o", ex_pc, '0);
		check_reg("waddr_o", waddr, '0);
		check_bit("inslot_o", ex_inslot, 1'b0);
	endtask

	task automatic reset_values;
		int e0;
		e0 = errors;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk); // nothing sampled yet
		expect_bubble;
		finish_test("reset", e0);
	endtask

	task automatic alu_case(input id_inst_u w, input int bitn,
		input logic [`ID_XLEN-1:0] d1, d2, e1, e2, input logic [`ID_REG_W-1:0] wa);
		apply(w, 32'h0040_0000, d1, d2);
		next_cycle;
		check_aluop("aluop_o", aluop, `ID_ALUOP_W'(1) << bitn);
		check_word("opr1_o", opr1, e1);
		check_word("opr2_o", opr2, e2);
		check_reg("waddr_o", waddr, wa);
		check_bit("wren_o", wren, 1'b1);
	endtask

	task automatic alu_ops;
		int e0;
		logic [`ID_XLEN-1:0] d1;
		logic [`ID_XLEN-1:0] d2;
		e0 = errors;
		d1 = $random(seed);
		d2 = $random(seed);
		alu_case(rtype(5'd1, 5'd2, 5'd3, 5'd0, `FN_ADDU), 0, d1, d2, d1, d2, 5'd3);
		alu_case(itype(`OP_ADDIU, 5'd4, 5'd5, 16'hfff0), 0, d1, d2, d1, 32'hffff_fff0, 5'd5);
		alu_case(itype(`OP_ANDI, 5'd6, 5'd7, 16'h8001), 4, d1, d2, d1, 32'h0000_8001, 5'd7);
		alu_case(itype(`OP_LUI, 5'd0, 5'd8, 16'h1234), 11, d1, d2, d1, 32'h0000_1234, 5'd8);
		alu_case(rtype(5'd0, 5'd9, 5'd10, 5'd5, `FN_SLL), 8, d1, d2, 32'd5, d2, 5'd10);
		alu_case(rtype(5'd11, 5'd12, 5'd13, 5'd0, `FN_SLT), 2, d1, d2, d1, d2, 5'd13);
		finish_test("alu ops", e0);
	endtask

	task automatic mem_case(input id_inst_u w, input logic [`ID_MEMOP_W-1:0] mem,
		input logic [`ID_MDUOP_W-1:0] mdu, input logic nf, we,
		input logic [`ID_XLEN-1:0] off);
		logic [`ID_XLEN-1:0] d2;
		d2 = $random(seed);
		apply(w, 32'h0040_0100, 32'h1000_0000, d2);
		next_cycle;
		check_memop("memop_o", memop, mem);
		check_mduop("mduop_o", mduop, mdu);
		check_word("offset_o", offset, off);
		check_word("rtvalue_o", rtvalue, d2);
		check_bit("nofwd_o", nofwd, nf);
		check_bit("wren_o", wren, we);
	endtask

	task automatic mem_ops;
		int e0;
		e0 = errors;
		mem_case(itype(`OP_LW, 5'd1, 5'd2, 16'h8004), 8'h10, 8'h00, 1'b1, 1'b1, 32'hffff_8004);
		mem_case(itype(`OP_LB, 5'd3, 5'd4, 16'h0010), 8'h01, 8'h00, 1'b1, 1'b1, 32'h0000_0010);
		mem_case(itype(`OP_SW, 5'd5, 5'd6, 16'hfffc), 8'h80, 8'h00, 1'b0, 1'b0, 32'hffff_fffc);
		// the low half of an R word reads as an immediate too
		mem_case(rtype(5'd7, 5'd8, 5'd0, 5'd0, `FN_MULT), 8'h00, 8'h01, 1'b0, 1'b0,
			32'h0000_0018);
		mem_case(rtype(5'd0, 5'd0, 5'd9, 5'd0, `FN_MFHI), 8'h00, 8'h10, 1'b1, 1'b1,
			32'h0000_4810);
		finish_test("memory/mdu", e0);
	endtask

	task automatic branch_case(input id_inst_u w, input logic [`ID_XLEN-1:0] addr, d1, d2,
		input logic taken, input logic [`ID_XLEN-1:0] target);
		apply(w, addr, d1, d2);
		check_bit("branch_en_o", branch_en, taken);
		check_word("branch_pc_o", branch_pc, target);
		check_bit("next_inslot_o", next_inslot, 1'b1);
	endtask

	task automatic branches;
		int e0;
		logic [`ID_XLEN-1:0] d;
		logic [`ID_XLEN-1:0] pos;
		logic [`ID_XLEN-1:0] neg;
		e0 = errors;
		d = $random(seed);
		pos = d & 32'h7fff_ffff;
		neg = d | 32'h8000_0000;
		branch_case(itype(`OP_BEQ, 5'd1, 5'd2, 16'h0010), 32'h0040_1000, d, d, 1'b1,
			32'h0040_1044);
		branch_case(itype(`OP_BEQ, 5'd1, 5'd2, 16'h0010), 32'h0040_1000, d, d ^ 32'd1, 1'b0,
			32'h0040_1044);
		branch_case(itype(`OP_BNE, 5'd1, 5'd2, 16'hfffc), 32'h0040_1000, d, d, 1'b0,
			32'h0040_0ff4); // backward
		branch_case(itype(`OP_BNE, 5'd1, 5'd2, 16'hfffc), 32'h0040_1000, d, ~d, 1'b1,
			32'h0040_0ff4);
		branch_case(itype(`OP_REGIMM, 5'd3, `RT_BGEZ, 16'h0100), 32'h0040_1000, pos, d, 1'b1,
			32'h0040_1404);
		branch_case(itype(`OP_REGIMM, 5'd3, `RT_BGEZ, 16'h0100), 32'h0040_1000, neg, d, 1'b0,
			32'h0040_1404);
		branch_case(itype(`OP_REGIMM, 5'd4, `RT_BLTZAL, 16'h0002), 32'h0040_1000, neg, d,
			1'b1, 32'h0040_100c);
		next_cycle;
		check_reg("link waddr_o", waddr, 5'd31);
		check_word("link opr1_o", opr1, 32'h0040_1000);
		check_word("link opr2_o", opr2, 32'd8);
		check_bit("link wren_o", wren, 1'b1);
		check_aluop("link aluop_o", aluop, `ID_ALUOP_W'(1));
		branch_case(jtype(`OP_J, 26'h012_3456), 32'hbfc0_0100, d, d, 1'b1, 32'hb048_d158);
		branch_case(rtype(5'd5, 5'd0, 5'd0, 5'd0, `FN_JR), 32'h0040_1000, d, pos, 1'b1, d);
		finish_test("branches", e0);
	endtask

	task automatic exc_case(input id_inst_u w, input logic [`ID_EXC_W-1:0] exp);
		apply(w, 32'h0040_0200, '0, '0);
		next_cycle;
		check_exc("excs_o", excs, exp);
		check_bit("has_exc_o", has_exc, 1'b1);
	endtask

	task automatic exceptions;
		int e0;
		e0 = errors;
		exc_case(rtype(5'd0, 5'd0, 5'd0, 5'd0, `FN_SYSCALL), 3'b001);
		exc_case(rtype(5'd0, 5'd0, 5'd0, 5'd0, `FN_BREAK), 3'b010);
		exc_case(itype(6'h3f, 5'd0, 5'd0, 16'h0000), 3'b100); // unused opcode
		finish_test("exceptions", e0);
	endtask

	// addresses and read enables follow the word in the same cycle
	task automatic read_case(input id_inst_u w, input logic r1, r2, slot);
		@(posedge clk);
		inst <= w;
		inslot <= slot;
		@(negedge clk);
		check_reg("reg1addr_o", reg1addr, w.r.rs);
		check_reg("reg2addr_o", reg2addr, w.r.rt);
		check_bit("ren1_o", ren1, r1);
		check_bit("ren2_o", ren2, r2);
		next_cycle;
		check_bit("inslot_o", ex_inslot, slot);
	endtask

	task automatic reg_reads;
		int e0;
		e0 = errors;
		read_case(rtype(5'd1, 5'd2, 5'd3, 5'd0, `FN_ADDU), 1'b1, 1'b1, 1'b1);
		read_case(itype(`OP_ADDIU, 5'd4, 5'd5, 16'h0001), 1'b1, 1'b0, 1'b0);
		read_case(itype(`OP_LUI, 5'd0, 5'd8, 16'h1234), 1'b0, 1'b0, 1'b1);
		read_case(rtype(5'd0, 5'd9, 5'd10, 5'd5, `FN_SLL), 1'b0, 1'b1, 1'b0);
		read_case(itype(`OP_SW, 5'd11, 5'd12, 16'h0004), 1'b1, 1'b1, 1'b1);
		read_case(itype(`OP_BEQ, 5'd13, 5'd14, 16'h0010), 1'b1, 1'b1, 1'b0);
		read_case(itype(`OP_REGIMM, 5'd15, `RT_BGEZ, 16'h0010), 1'b1, 1'b0, 1'b1);
		read_case(jtype(`OP_J, 26'h000_0040), 1'b0, 1'b0, 1'b1);
		read_case(rtype(5'd16, 5'd0, 5'd0, 5'd0, `FN_JR), 1'b1, 1'b0, 1'b0);
		finish_test("register reads", e0);
	endtask

	task automatic expect_held(input logic [`ID_XLEN-1:0] d1, d2);
		check_aluop("held aluop_o", aluop, `ID_ALUOP_W'(2));
		check_word("held opr1_o", opr1, d1);
		check_word("held opr2_o", opr2, d2);
		check_reg("held waddr_o", waddr, 5'd3);
		check_word("held pc_o", ex_pc, 32'h0040_2000);
		check_bit("held wren_o", wren, 1'b1);
	endtask

	task automatic stall_flush;
		int e0;
		logic [`ID_XLEN-1:0] d1;
		logic [`ID_XLEN-1:0] d2;
		e0 = errors;
		d1 = $random(seed);
		d2 = $random(seed);
		apply(rtype(5'd1, 5'd2, 5'd3, 5'd0, `FN_SUBU), 32'h0040_2000, d1, d2);
		next_cycle;
		@(posedge clk);
		stall <= 1'b1;
		inst <= itype(`OP_ORI, 5'd4, 5'd5, 16'h00ff);
		pc <= 32'h0040_2004;
		reg1data <= ~d1;
		reg2data <= ~d2;
		next_cycle;
		next_cycle;
		expect_held(d1, d2);
		@(posedge clk);
		flush <= 1'b1; // stall still high
		next_cycle;
		expect_held(d1, d2);
		@(posedge clk);
		stall <= 1'b0;
		next_cycle;
		expect_bubble;
		@(posedge clk);
		flush <= 1'b0;
		finish_test("stall/flush", e0);
	endtask

	initial begin
		rst = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		pc = '0;
		inst = '0;
		inslot = 1'b0;
		reg1data = '0;
		reg2data = '0;
		reset_values;
		alu_ops;
		mem_ops;
		branches;
		exceptions;
		reg_reads;
		stall_flush;
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+source
source/id_pkg.sv
source/id_inst_decoder.sv
source/id_branch_unit.sv
source/id_ex_latch.sv
source/id_stage.sv
sim/id_stage_tb.sv

// File: Makefile
TOP = id_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir sim.log
